// ==== include/fwrisc_exec_defs.svh ====
`ifndef FWRISC_EXEC_DEFS_SVH
`define FWRISC_EXEC_DEFS_SVH

// width of data and of the program counter
`define FWRISC_XLEN 32

// number of architectural registers
`define FWRISC_NUM_REGS 32

// where execution starts after reset
`define FWRISC_RESET_PC 32'h0000_0100

`endif

// ==== src/fwrisc_isa_pkg.sv ====
`default_nettype none

package fwrisc_isa_pkg;

	// major opcode of the 32-bit conditional branches
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// B-type funct3 values
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// compressed quadrant 1 and its CB-format branches
	localparam logic [1:0] C_QUAD1 = 2'b01;
	localparam logic [2:0] C_F3_BEQZ = 3'b110;
	localparam logic [2:0] C_F3_BNEZ = 3'b111;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	// a compressed word only occupies the low half
	typedef struct packed {
		logic [15:0] unused;
		logic [2:0] funct3;
		logic imm8;
		logic [1:0] imm4_3;
		logic [2:0] rs1p;
		logic [1:0] imm7_6;
		logic [1:0] imm2_1;
		logic imm5;
		logic [1:0] quad;
	} cb_fmt_t;

	typedef union packed {
		b_fmt_t b_fmt;
		cb_fmt_t cb_fmt;
	} branch_instr_u;

endpackage

`default_nettype wire

// ==== src/fwrisc_exec_pkg.sv ====
`default_nettype none

package fwrisc_exec_pkg;

	// what kind of work execute has to do
	typedef enum logic [2:0] {
		OP_TYPE_BRANCH = 3'd0,
		OP_TYPE_ILLEGAL = 3'd1
	} op_type_e;

	// branch compare operations
	typedef enum logic [2:0] {
		OP_EQ = 3'd0,
		OP_NE = 3'd1,
		OP_LT = 3'd2,
		OP_GE = 3'd3,
		OP_LTU = 3'd4,
		OP_GEU = 3'd5
	} cmp_op_e;

endpackage

`default_nettype wire

// ==== src/fwrisc_exec_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fwrisc_exec_defs.svh"

interface fwrisc_exec_if
	import fwrisc_exec_pkg::*;
	();

	// one-cycle strobe per decoded instruction
	logic decode_valid;
	op_type_e op_type;
	cmp_op_e op;
	logic [`FWRISC_XLEN-1:0] op_a;
	logic [`FWRISC_XLEN-1:0] op_b;
	// branch offset, already sign-extended
	logic [`FWRISC_XLEN-1:0] op_c;
	logic instr_c;

	modport decoder(
		output decode_valid, op_type, op,
		output op_a, op_b, op_c, instr_c
	);

	modport execute(
		input decode_valid, op_type, op,
		input op_a, op_b, op_c, instr_c
	);

	modport monitor(
		input decode_valid, op_type, op,
		input op_a, op_b, op_c, instr_c
	);

endinterface

`default_nettype wire

// ==== src/fwrisc_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fwrisc_exec_defs.svh"

module fwrisc_regfile (
	input wire clock,
	input wire reset,
	input wire wen,
	input wire [4:0] waddr,
	input wire [`FWRISC_XLEN-1:0] wdata,
	input wire [4:0] raddr_a,
	input wire [4:0] raddr_b,
	output logic [`FWRISC_XLEN-1:0] rdata_a,
	output logic [`FWRISC_XLEN-1:0] rdata_b
);

	logic [`FWRISC_XLEN-1:0] regs [0:`FWRISC_NUM_REGS-1];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `FWRISC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 always reads as zero, whatever the array holds
	assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

	// the rest of the core never targets x0 with a write
	assert property (@(posedge clock) disable iff (reset)
		wen |-> waddr != 5'd0);

endmodule

`default_nettype wire

// ==== src/fwrisc_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fwrisc_exec_defs.svh"

module fwrisc_decode
	import fwrisc_isa_pkg::*;
	import fwrisc_exec_pkg::*;
(
	input wire clock,
	input wire reset,
	input wire instr_valid,
	input wire [31:0] instr,
	output logic [4:0] raddr_a,
	output logic [4:0] raddr_b,
	input wire [`FWRISC_XLEN-1:0] rdata_a,
	input wire [`FWRISC_XLEN-1:0] rdata_b,
	fwrisc_exec_if.decoder dec
);

	branch_instr_u word;
	logic is_compressed;
	op_type_e dec_type;
	cmp_op_e dec_op;
	logic [`FWRISC_XLEN-1:0] dec_imm;

	assign word = instr;

	// anything other than 2'b11 in the low bits is a 16-bit encoding
	assign is_compressed = (word.cb_fmt.quad != 2'b11);

	// CB branches compare rs1' (x8..x15) against x0
	always_comb begin
		if (is_compressed) begin
			raddr_a = {2'b01, word.cb_fmt.rs1p};
			raddr_b = 5'd0;
		end else begin
			raddr_a = word.b_fmt.rs1;
			raddr_b = word.b_fmt.rs2;
		end
	end

	always_comb begin
		dec_type = OP_TYPE_ILLEGAL;
		dec_op = OP_EQ;
		if (is_compressed) begin
			dec_imm = {{23{word.cb_fmt.imm8}}, word.cb_fmt.imm8, word.cb_fmt.imm7_6,
				word.cb_fmt.imm5, word.cb_fmt.imm4_3, word.cb_fmt.imm2_1, 1'b0};
			if (word.cb_fmt.quad == C_QUAD1) begin
				if (word.cb_fmt.funct3 == C_F3_BEQZ) begin
					dec_type = OP_TYPE_BRANCH;
					dec_op = OP_EQ;
				end else if (word.cb_fmt.funct3 == C_F3_BNEZ) begin
					dec_type = OP_TYPE_BRANCH;
					dec_op = OP_NE;
				end
			end
		end else begin
			dec_imm = {{19{word.b_fmt.imm12}}, word.b_fmt.imm12, word.b_fmt.imm11,
				word.b_fmt.imm10_5, word.b_fmt.imm4_1, 1'b0};
			if (word.b_fmt.opcode == OPC_BRANCH) begin
				dec_type = OP_TYPE_BRANCH;
				case (word.b_fmt.funct3)
					F3_BEQ: dec_op = OP_EQ;
					F3_BNE: dec_op = OP_NE;
					F3_BLT: dec_op = OP_LT;
					F3_BGE: dec_op = OP_GE;
					F3_BLTU: dec_op = OP_LTU;
					F3_BGEU: dec_op = OP_GEU;
					// funct3 010 and 011 are reserved in the branch space
					default: dec_type = OP_TYPE_ILLEGAL;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dec.decode_valid <= 1'b0;
		end else begin
			dec.decode_valid <= instr_valid;
		end
	end

	always_ff @(posedge clock) begin
		dec.op_type <= dec_type;
		dec.op <= dec_op;
		dec.op_a <= rdata_a;
		dec.op_b <= rdata_b;
		dec.op_c <= dec_imm;
		dec.instr_c <= is_compressed;
	end

	// a compressed word reads x0 as its second operand, which the register file returns as zero
	assert property (@(posedge clock) disable iff (reset)
		dec.decode_valid && dec.instr_c |-> dec.op_b == '0);

endmodule

`default_nettype wire

// ==== src/fwrisc_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fwrisc_exec_defs.svh"

module fwrisc_exec
	import fwrisc_exec_pkg::*;
(
	input wire clock,
	input wire reset,
	fwrisc_exec_if.execute ex,
	output logic instr_complete,
	output logic branch_taken,
	output logic illegal,
	output logic [`FWRISC_XLEN-1:0] pc
);

	logic cmp_true;
	logic [`FWRISC_XLEN-1:0] pc_seq;
	logic [`FWRISC_XLEN-1:0] pc_target;

	always_comb begin
		case (ex.op)
			OP_EQ: cmp_true = (ex.op_a == ex.op_b);
			OP_NE: cmp_true = (ex.op_a != ex.op_b);
			OP_LT: cmp_true = ($signed(ex.op_a) < $signed(ex.op_b));
			OP_GE: cmp_true = ($signed(ex.op_a) >= $signed(ex.op_b));
			OP_LTU: cmp_true = (ex.op_a < ex.op_b);
			OP_GEU: cmp_true = (ex.op_a >= ex.op_b);
			default: cmp_true = 1'b0;
		endcase
	end

	// compressed instructions are two bytes long
	assign pc_seq = pc + (ex.instr_c ? `FWRISC_XLEN'd2 : `FWRISC_XLEN'd4);
	assign pc_target = pc + ex.op_c;

	always_ff @(posedge clock) begin
		if (reset) begin
			instr_complete <= 1'b0;
			branch_taken <= 1'b0;
			illegal <= 1'b0;
			pc <= `FWRISC_RESET_PC;
		end else begin
			instr_complete <= ex.decode_valid;
			branch_taken <= 1'b0;
			illegal <= 1'b0;
			if (ex.decode_valid) begin
				if (ex.op_type == OP_TYPE_BRANCH) begin
					branch_taken <= cmp_true;
					pc <= cmp_true ? pc_target : pc_seq;
				end else begin
					// an illegal word completes in place
					illegal <= 1'b1;
				end
			end
		end
	end

	// offsets from decode are always even, so pc never loses alignment
	assert property (@(posedge clock) disable iff (reset)
		pc[0] == 1'b0);

endmodule

`default_nettype wire

// ==== src/fwrisc_exec_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fwrisc_exec_defs.svh"

module fwrisc_exec_checker
	import fwrisc_exec_pkg::*;
(
	input wire clock,
	input wire reset,
	fwrisc_exec_if.monitor mon,
	input wire instr_complete,
	input wire [`FWRISC_XLEN-1:0] pc
);

	// snapshot of the instruction that is currently in execute
	logic [`FWRISC_XLEN-1:0] pc_last;
	logic instr_c_last;
	logic [`FWRISC_XLEN-1:0] op_a_last;
	logic [`FWRISC_XLEN-1:0] op_b_last;
	logic [`FWRISC_XLEN-1:0] op_c_last;
	cmp_op_e op_last;
	op_type_e op_type_last;
	logic cond;
	logic [`FWRISC_XLEN-1:0] pc_exp;

	always_ff @(posedge clock) begin
		if (mon.decode_valid) begin
			pc_last <= pc;
			instr_c_last <= mon.instr_c;
			op_a_last <= mon.op_a;
			op_b_last <= mon.op_b;
			op_c_last <= mon.op_c;
			op_last <= mon.op;
			op_type_last <= mon.op_type;
		end
	end

	// signed order is checked by flipping the sign bits and comparing unsigned
	always_comb begin
		case (op_last)
			OP_EQ: cond = (op_a_last == op_b_last);
			OP_NE: cond = !(op_a_last == op_b_last);
			OP_LT: cond = ({~op_a_last[31], op_a_last[30:0]} < {~op_b_last[31], op_b_last[30:0]});
			OP_GE: cond = !({~op_a_last[31], op_a_last[30:0]} < {~op_b_last[31], op_b_last[30:0]});
			OP_LTU: cond = (op_a_last < op_b_last);
			OP_GEU: cond = !(op_a_last < op_b_last);
			default: cond = 1'b0;
		endcase
	end

	always_comb begin
		if (op_type_last != OP_TYPE_BRANCH) begin
			pc_exp = pc_last;
		end else if (cond) begin
			pc_exp = pc_last + op_c_last;
		end else begin
			pc_exp = pc_last + (instr_c_last ? 32'd2 : 32'd4);
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		instr_complete |-> pc == pc_exp);

	assert property (@(posedge clock) disable iff (reset)
		mon.decode_valid && mon.op_type == OP_TYPE_BRANCH
		|-> mon.op inside {OP_EQ, OP_NE, OP_LT, OP_GE, OP_LTU, OP_GEU});

	assert property (@(posedge clock) disable iff (reset)
		mon.decode_valid |=> instr_complete);

	assert property (@(posedge clock) disable iff (reset)
		instr_complete |-> $past(mon.decode_valid));

endmodule

`default_nettype wire

// ==== src/fwrisc_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fwrisc_exec_defs.svh"

module fwrisc_branch_unit (
	input wire clock,
	input wire reset,
	input wire instr_valid,
	input wire [31:0] instr,
	input wire reg_wen,
	input wire [4:0] reg_waddr,
	input wire [`FWRISC_XLEN-1:0] reg_wdata,
	output wire instr_complete,
	output wire branch_taken,
	output wire illegal,
	output wire [`FWRISC_XLEN-1:0] pc
);

	wire [4:0] raddr_a;
	wire [4:0] raddr_b;
	wire [`FWRISC_XLEN-1:0] rdata_a;
	wire [`FWRISC_XLEN-1:0] rdata_b;

	fwrisc_exec_if i_exec_if ();

	fwrisc_regfile i_regfile (
		.clock(clock),
		.reset(reset),
		.wen(reg_wen),
		.waddr(reg_waddr),
		.wdata(reg_wdata),
		.raddr_a(raddr_a),
		.raddr_b(raddr_b),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b)
	);

	fwrisc_decode i_decode (
		.clock(clock),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.raddr_a(raddr_a),
		.raddr_b(raddr_b),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.dec(i_exec_if.decoder)
	);

	fwrisc_exec i_exec (
		.clock(clock),
		.reset(reset),
		.ex(i_exec_if.execute),
		.instr_complete(instr_complete),
		.branch_taken(branch_taken),
		.illegal(illegal),
		.pc(pc)
	);

	// the checker sees the same decoded stream as execute
	fwrisc_exec_checker i_exec_checker (
		.clock(clock),
		.reset(reset),
		.mon(i_exec_if.monitor),
		.instr_complete(instr_complete),
		.pc(pc)
	);

endmodule

`default_nettype wire

// ==== verification/fwrisc_branch_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fwrisc_exec_defs.svh"

module fwrisc_branch_unit_tb
	import fwrisc_isa_pkg::*;
();

	typedef enum {K_BEQ, K_BNE, K_BLT, K_BGE, K_BLTU, K_BGEU, K_CBEQZ, K_CBNEZ, K_ILLEGAL} kind_e;

	typedef struct {
		logic [31:0] word;
		kind_e kind;
		logic is_c;
		int rs1;
		int rs2;
		int offset;
		// the next entry issues in the very next cycle
		logic burst;
	} stim_entry_t;

	typedef struct {
		int idx;
		logic taken;
		logic illegal;
		logic [31:0] pc;
	} result_t;

	logic clock;
	logic reset;
	logic instr_valid;
	logic [31:0] instr;
	logic reg_wen;
	logic [4:0] reg_waddr;
	logic [`FWRISC_XLEN-1:0] reg_wdata;
	wire instr_complete;
	wire branch_taken;
	wire illegal;
	wire [`FWRISC_XLEN-1:0] pc;

	stim_entry_t stim_q[$];
	result_t expect_q[$];
	int issue_cycles[$];
	logic [31:0] model_regs [0:31];
	logic [31:0] model_pc;
	int cycle = 0;
	int timeout_cycles = 0;
	int errors = 0;

	fwrisc_branch_unit i_fwrisc_branch_unit (
		.clock(clock),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.reg_wen(reg_wen),
		.reg_waddr(reg_waddr),
		.reg_wdata(reg_wdata),
		.instr_complete(instr_complete),
		.branch_taken(branch_taken),
		.illegal(illegal),
		.pc(pc)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) cycle <= cycle + 1;

	initial begin
		wait (timeout_cycles != 0 && cycle >= timeout_cycles);
		$display("timeout after %0d cycles with %0d results outstanding", cycle, expect_q.size());
		$display("Test failed");
		$finish;
	end

	function automatic void report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		errors++;
		$display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, expected);
	endfunction

	// B-type layout: imm[12|10:5] rs2 rs1 funct3 imm[4:1|11] opcode
	function automatic logic [31:0] encode_branch(input logic [2:0] f3, input int rs1,
		input int rs2, input int offset);
		logic [31:0] o;
		o = offset;
		return {o[12], o[10:5], rs2[4:0], rs1[4:0], f3, o[4:1], o[11], OPC_BRANCH};
	endfunction

	// CB layout: funct3 imm[8|4:3] rs1' imm[7:6|2:1|5] quadrant
	function automatic logic [31:0] encode_cbranch(input logic [2:0] f3, input int rs1,
		input int offset);
		logic [31:0] o;
		o = offset;
		return {16'h0000, f3, o[8], o[4:3], rs1[2:0], o[7:6], o[2:1], o[5], C_QUAD1};
	endfunction

	function automatic logic branch_holds(input kind_e kind, input logic [31:0] a,
		input logic [31:0] b);
		case (kind)
			K_BEQ, K_CBEQZ: return a == b;
			K_BNE, K_CBNEZ: return a != b;
			K_BLT: return $signed(a) < $signed(b);
			K_BGE: return $signed(a) >= $signed(b);
			K_BLTU: return a < b;
			K_BGEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic void add_branch(input kind_e kind, input int rs1, input int rs2,
		input int offset, input logic burst);
		stim_entry_t e;
		e.kind = kind;
		e.rs1 = rs1;
		e.rs2 = rs2;
		e.offset = offset;
		e.burst = burst;
		e.is_c = (kind == K_CBEQZ || kind == K_CBNEZ);
		case (kind)
			K_BEQ: e.word = encode_branch(F3_BEQ, rs1, rs2, offset);
			K_BNE: e.word = encode_branch(F3_BNE, rs1, rs2, offset);
			K_BLT: e.word = encode_branch(F3_BLT, rs1, rs2, offset);
			K_BGE: e.word = encode_branch(F3_BGE, rs1, rs2, offset);
			K_BLTU: e.word = encode_branch(F3_BLTU, rs1, rs2, offset);
			K_BGEU: e.word = encode_branch(F3_BGEU, rs1, rs2, offset);
			K_CBEQZ: e.word = encode_cbranch(C_F3_BEQZ, rs1, offset);
			default: e.word = encode_cbranch(C_F3_BNEZ, rs1, offset);
		endcase
		stim_q.push_back(e);
	endfunction

	function automatic void add_illegal(input logic [31:0] word, input logic is_c);
		stim_entry_t e;
		e = '{word, K_ILLEGAL, is_c, 0, 0, 0, 1'b0};
		stim_q.push_back(e);
	endfunction

	// x1 == x2, x3 < 0 <= x4, x5 == x6, x9 == 0, x8 and x10 nonzero
	function automatic void build_stim();
		add_branch(K_BEQ, 1, 2, 16, 1'b0);
		add_branch(K_BEQ, 1, 3, 8, 1'b0);
		add_branch(K_BNE, 1, 3, -12, 1'b0);
		add_branch(K_BNE, 1, 2, -20, 1'b0);
		add_branch(K_BEQ, 5, 6, -32, 1'b0);
		add_branch(K_BLT, 3, 4, 24, 1'b0);
		add_branch(K_BLTU, 3, 4, 24, 1'b0);
		add_branch(K_BGE, 3, 4, 40, 1'b0);
		add_branch(K_BGEU, 3, 4, 40, 1'b0);
		add_branch(K_BLT, 4, 3, -8, 1'b0);
		add_branch(K_BGEU, 4, 3, -8, 1'b0);
		add_branch(K_CBEQZ, 9, 0, 10, 1'b0);
		add_branch(K_CBEQZ, 8, 0, 10, 1'b0);
		add_branch(K_CBNEZ, 8, 0, -6, 1'b0);
		add_branch(K_CBNEZ, 9, 0, 20, 1'b0);
		// a run issued on consecutive cycles
		add_branch(K_BNE, 1, 3, 8, 1'b1);
		add_branch(K_CBNEZ, 10, 0, 4, 1'b1);
		add_branch(K_BLTU, 4, 3, -16, 1'b1);
		add_branch(K_CBEQZ, 10, 0, 6, 1'b1);
		add_branch(K_BGE, 4, 3, 12, 1'b0);
		add_illegal(32'h0000_0013, 1'b0);
		add_illegal(32'h0000_0001, 1'b1);
		add_illegal(encode_branch(3'b010, 1, 2, 8), 1'b0);
	endfunction

	task automatic load_registers();
		for (int r = 1; r < 16; r++) model_regs[r] = $urandom;
		model_regs[1][31] = 1'b0;
		model_regs[2] = model_regs[1];
		model_regs[3][31] = 1'b1;
		model_regs[4][31] = 1'b0;
		model_regs[6] = model_regs[5];
		model_regs[8][0] = 1'b1;
		model_regs[9] = '0;
		model_regs[10][0] = 1'b1;
		for (int r = 1; r < 16; r++) begin
			@(posedge clock);
			reg_wen <= 1'b1;
			reg_waddr <= r[4:0];
			reg_wdata <= model_regs[r];
		end
		@(posedge clock);
		reg_wen <= 1'b0;
	endtask

	// the model walks its own pc in issue order, which is the order execute sees
	task automatic issue_entry(input int idx);
		stim_entry_t e;
		result_t r;
		e = stim_q[idx];
		r.idx = idx;
		r.illegal = (e.kind == K_ILLEGAL);
		r.taken = !r.illegal && branch_holds(e.kind, model_regs[e.rs1], model_regs[e.rs2]);
		if (r.illegal)
			r.pc = model_pc;
		else if (r.taken)
			r.pc = model_pc + e.offset;
		else
			r.pc = model_pc + (e.is_c ? 32'd2 : 32'd4);
		model_pc = r.pc;
		expect_q.push_back(r);
		instr_valid <= 1'b1;
		instr <= e.word;
	endtask

	always @(negedge clock) begin : completion_monitor
		result_t exp;
		int issued;
		if (reset === 1'b0 && instr_valid) issue_cycles.push_back(cycle);
		if (reset === 1'b0 && instr_complete) begin
			if (expect_q.size() == 0) begin
				errors++;
				$display("instr_complete was high with no instruction outstanding");
			end else begin
				exp = expect_q.pop_front();
				issued = issue_cycles.pop_front();
				assert (cycle - issued == 2) else begin
					errors++;
					$display("entry %0d completed %0d cycles after issue instead of 2",
						exp.idx, cycle - issued);
				end
				assert (pc == exp.pc)
				else report_mismatch($sformatf("pc, entry %0d", exp.idx), pc, exp.pc);
				assert (branch_taken == exp.taken)
				else report_mismatch($sformatf("branch_taken, entry %0d", exp.idx),
					branch_taken, exp.taken);
				assert (illegal == exp.illegal)
				else report_mismatch($sformatf("illegal, entry %0d", exp.idx),
					illegal, exp.illegal);
			end
		end
	end

	initial begin
		void'($urandom(25562));
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		reg_wen = 1'b0;
		reg_waddr = '0;
		reg_wdata = '0;
		model_pc = `FWRISC_RESET_PC;
		for (int r = 0; r < 32; r++) model_regs[r] = '0;
		build_stim();
		timeout_cycles = stim_q.size() * 4 + 50;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		assert (pc == `FWRISC_RESET_PC)
		else report_mismatch("pc after reset", pc, `FWRISC_RESET_PC);
		assert (!instr_complete)
		else report_mismatch("instr_complete after reset", instr_complete, 0);
		assert (!branch_taken)
		else report_mismatch("branch_taken after reset", branch_taken, 0);
		assert (!illegal)
		else report_mismatch("illegal after reset", illegal, 0);
		load_registers();
		for (int i = 0; i < stim_q.size(); i++) begin
			@(posedge clock);
			issue_entry(i);
			if (!stim_q[i].burst) begin
				@(posedge clock);
				instr_valid <= 1'b0;
				while (expect_q.size() != 0) @(posedge clock);
			end
		end
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fwrisc_branch_unit.f ====
+incdir+include
src/fwrisc_isa_pkg.sv
src/fwrisc_exec_pkg.sv
src/fwrisc_exec_if.sv
src/fwrisc_regfile.sv
src/fwrisc_decode.sv
src/fwrisc_exec.sv
src/fwrisc_exec_checker.sv
src/fwrisc_branch_unit.sv
verification/fwrisc_branch_unit_tb.sv

// ==== Bender.yml ====
package:
  name: fwrisc_branch_unit

sources:
  - include_dirs:
      - include
    files:
      - src/fwrisc_isa_pkg.sv
      - src/fwrisc_exec_pkg.sv
      - src/fwrisc_exec_if.sv
      - src/fwrisc_regfile.sv
      - src/fwrisc_decode.sv
      - src/fwrisc_exec.sv
      - src/fwrisc_exec_checker.sv
      - src/fwrisc_branch_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/fwrisc_branch_unit_tb.sv
